/* cpld_pkg.sv */
// Shared types for the serial link controller; links are oversampled bit strobes, codes outside the four listed select no device.
package cpld_pkg;

  // Widths that carry a meaning.
  localparam int BYTE_W    = 8;
  localparam int BIT_IDX_W = 3;
  localparam int DEV_SEL_W = 3;
  localparam int DEV_NSS_W = 3;

  // One data byte on a link, also the mailbox register width.
  typedef logic [BYTE_W-1:0] byte_t;

  // Bit position within the byte being shifted.
  typedef logic [BIT_IDX_W-1:0] bit_idx_t;

  // Device select code driven by the coprocessor.
  typedef logic [DEV_SEL_W-1:0] dev_sel_t;

  // Active-low chip selects for the external devices.
  typedef logic [DEV_NSS_W-1:0] dev_nss_t;

  // Device select codes.
  // Any other code routes the coprocessor nowhere.
  localparam dev_sel_t DEV_LOGIC  = 3'd0;
  localparam dev_sel_t DEV_SDCARD = 3'd1;
  localparam dev_sel_t DEV_USB    = 3'd2;
  localparam dev_sel_t DEV_FPGA   = 3'd3;

  // Bit positions inside dev_nss_t.
  localparam int DEV_NSS_SDCARD = 0;
  localparam int DEV_NSS_USB    = 1;
  localparam int DEV_NSS_FPGA   = 2;

  // All selects released.
  localparam dev_nss_t DEV_NSS_IDLE = 3'b111;

  // First byte of every frame.
  // Unlisted values make the engine ignore the rest of the frame.
  typedef enum logic [BYTE_W-1:0] {
    OP_WRITE_REG  = 8'h01,
    OP_READ_PEER  = 8'h02,
    OP_ACCESS_RAM = 8'h03,
    OP_PEER_RESET = 8'h04
  } opcode_e;

  // Frame engine states.
  typedef enum logic [2:0] {
    ST_OPCODE,
    ST_WRITE,
    ST_READ,
    ST_RAM,
    ST_RESET,
    ST_IGNORE
  } engine_state_e;

  // One serial link, nss is active low.
  typedef struct packed {
    logic nss;
    logic bit_vld;
    logic mosi;
  } link_t;

  // RAM pass-through request from one engine.
  typedef struct packed {
    logic active;
    logic bit_vld;
    logic mosi;
  } ram_req_t;

endpackage

/* link_router.sv */
// Routes port links to the engines; the last port is the coprocessor and reaches its engine only on DEV_LOGIC.
`timescale 1ns/1ps

module link_router #(
  parameter int NUM_PORTS = 2
) (
  input  logic               cop_sck,
  input  logic               rst_n,
  input  cpld_pkg::link_t    port_link [NUM_PORTS],
  input  cpld_pkg::dev_sel_t cop_select,
  output cpld_pkg::link_t    eng_link [NUM_PORTS],
  output cpld_pkg::dev_nss_t dev_nss,
  output cpld_pkg::dev_sel_t dev_route
);

  // Coprocessor port index.
  localparam int COP_PORT = NUM_PORTS - 1;

  // High when the coprocessor talks to the mailbox logic.
  logic logic_sel;

  assign logic_sel = (cop_select == cpld_pkg::DEV_LOGIC);

  // Links pass straight to the engines.
  // The coprocessor link is closed off while a device is selected,
  // so its engine sees an idle frame and stays in ST_OPCODE.
  always_comb begin
    for (int i = 0; i < NUM_PORTS; i++) begin
      eng_link[i] = port_link[i];
    end
    if (!logic_sel) begin
      eng_link[COP_PORT].nss     = 1'b1;
      eng_link[COP_PORT].bit_vld = 1'b0;
    end
  end

  // Registered chip selects and miso route.
  // dev_route lags cop_select by one cycle to line up with the engine miso register.
  always_ff @(posedge cop_sck or negedge rst_n) begin
    if (!rst_n) begin
      dev_nss   <= cpld_pkg::DEV_NSS_IDLE;
      dev_route <= cpld_pkg::DEV_LOGIC;
    end else begin
      // One select at most goes low.
      dev_nss[cpld_pkg::DEV_NSS_SDCARD] <= (cop_select != cpld_pkg::DEV_SDCARD);
      dev_nss[cpld_pkg::DEV_NSS_USB]    <= (cop_select != cpld_pkg::DEV_USB);
      dev_nss[cpld_pkg::DEV_NSS_FPGA]   <= (cop_select != cpld_pkg::DEV_FPGA);
      dev_route                         <= cop_select;
    end
  end

endmodule

/* frame_engine.sv */
// Per-port frame decoder; bits go LSB first, a partial byte at frame end is dropped, slots under four cycles are unsupported.
`timescale 1ns/1ps

module frame_engine (
  input  logic               cop_sck,
  input  logic               rst_n,
  input  cpld_pkg::link_t    eng_link,
  input  cpld_pkg::byte_t    peer_reg,
  input  logic               ram_grant_miso,
  output cpld_pkg::byte_t    mbox_reg,
  output cpld_pkg::ram_req_t ram_req,
  output logic               eng_miso,
  output logic               reset_req
);

  // Frame state and bit position.
  cpld_pkg::engine_state_e state;
  cpld_pkg::engine_state_e op_state;
  cpld_pkg::bit_idx_t      bit_cnt;

  // Incoming byte assembly and outgoing reply bits.
  cpld_pkg::byte_t shift_q;
  cpld_pkg::byte_t byte_in;
  cpld_pkg::byte_t reply_sr;
  logic            reply_bit;

  // Per-bit strobes.
  logic bit_take;
  logic byte_done;
  logic read_next;

  // A bit counts only inside a frame.
  assign bit_take  = eng_link.bit_vld && !eng_link.nss;
  assign byte_done = bit_take && (bit_cnt == '1);

  // Full byte as it stands on the eighth bit.
  assign byte_in = {eng_link.mosi, shift_q[cpld_pkg::BYTE_W-1:1]};

  // Opcode decode.
  always_comb begin
    case (cpld_pkg::opcode_e'(byte_in))
      cpld_pkg::OP_WRITE_REG:  op_state = cpld_pkg::ST_WRITE;
      cpld_pkg::OP_READ_PEER:  op_state = cpld_pkg::ST_READ;
      cpld_pkg::OP_ACCESS_RAM: op_state = cpld_pkg::ST_RAM;
      cpld_pkg::OP_PEER_RESET: op_state = cpld_pkg::ST_RESET;
      default:                 op_state = cpld_pkg::ST_IGNORE;
    endcase
  end

  // True when the state after this edge is a peer read.
  assign read_next = (state == cpld_pkg::ST_READ) ||
                     ((state == cpld_pkg::ST_OPCODE) && byte_done &&
                      (op_state == cpld_pkg::ST_READ));

  // Control state and mailbox.
  always_ff @(posedge cop_sck or negedge rst_n) begin
    if (!rst_n) begin
      state     <= cpld_pkg::ST_OPCODE;
      bit_cnt   <= '0;
      mbox_reg  <= '0;
      reply_bit <= 1'b0;
    end else if (eng_link.nss) begin
      // A closed frame starts over on the next opcode.
      state     <= cpld_pkg::ST_OPCODE;
      bit_cnt   <= '0;
      reply_bit <= 1'b0;
    end else if (bit_take) begin
      bit_cnt <= bit_cnt + 1'b1;
      if (byte_done && (state == cpld_pkg::ST_OPCODE)) begin
        state <= op_state;
      end
      if (byte_done && (state == cpld_pkg::ST_WRITE)) begin
        mbox_reg <= byte_in;
      end
      // Bit 0 of each reply byte comes straight from the peer.
      if (read_next) begin
        reply_bit <= byte_done ? peer_reg[0] : reply_sr[0];
      end else begin
        reply_bit <= 1'b0;
      end
    end
  end

  // Shift registers.
  // The peer byte is captured once per byte so a change mid-byte does not tear it.
  always_ff @(posedge cop_sck) begin
    if (bit_take) begin
      shift_q <= byte_in;
      if (byte_done) begin
        reply_sr <= {1'b0, peer_reg[cpld_pkg::BYTE_W-1:1]};
      end else begin
        reply_sr <= {1'b0, reply_sr[cpld_pkg::BYTE_W-1:1]};
      end
    end
  end

  // RAM pass-through is live only inside the frame.
  assign ram_req.active  = (state == cpld_pkg::ST_RAM) && !eng_link.nss;
  assign ram_req.bit_vld = ram_req.active && eng_link.bit_vld;
  assign ram_req.mosi    = ram_req.active && eng_link.mosi;

  // RAM return is already registered in the arbiter.
  assign eng_miso = (state == cpld_pkg::ST_RAM) ? ram_grant_miso : reply_bit;

  // Peer reset drops as soon as nss rises.
  assign reset_req = (state == cpld_pkg::ST_RESET) && !eng_link.nss;

  // Senders keep their strobes inside the frame.
  a_bit_in_frame : assert property (@(posedge cop_sck) disable iff (!rst_n)
    eng_link.bit_vld |-> !eng_link.nss)
    else $error("bit_vld while nss high");

  // RAM traffic only comes from a decoded RAM frame.
  a_ram_in_state : assert property (@(posedge cop_sck) disable iff (!rst_n)
    ram_req.active |-> (state == cpld_pkg::ST_RAM) &&
                       ($past(ram_req.active) ||
                        $past(byte_done && (op_state == cpld_pkg::ST_RAM))))
    else $error("ram_req active without a decoded RAM opcode");

endmodule

/* shared_bus_arbiter.sv */
// RAM owner is the lowest port with a nonzero mailbox, else port 0; only one port may run a RAM frame at a time.
`timescale 1ns/1ps

module shared_bus_arbiter #(
  parameter int NUM_PORTS = 2
) (
  input  logic                 cop_sck,
  input  logic                 rst_n,
  input  cpld_pkg::byte_t      mbox_reg [NUM_PORTS],
  input  cpld_pkg::ram_req_t   ram_req [NUM_PORTS],
  input  logic [NUM_PORTS-1:0] eng_miso,
  input  logic [NUM_PORTS-1:0] reset_req,
  input  cpld_pkg::dev_sel_t   dev_route,
  input  logic                 ram_miso,
  input  logic                 dev_miso,
  output cpld_pkg::link_t      ram_link,
  output logic                 ram_grant_miso,
  output logic [NUM_PORTS-1:0] port_miso,
  output logic                 peer_nreset
);

  localparam int OWNER_W  = $clog2(NUM_PORTS);
  localparam int COP_PORT = NUM_PORTS - 1;

  logic [OWNER_W-1:0]   owner;
  cpld_pkg::ram_req_t   owner_req;
  logic [NUM_PORTS-1:0] active_q;

  // Priority search, lowest index wins.
  always_comb begin
    owner = '0;
    for (int i = NUM_PORTS - 1; i >= 0; i--) begin
      if (mbox_reg[i] != '0) begin
        owner = OWNER_W'(i);
      end
    end
  end

  assign owner_req = ram_req[owner];

  // RAM link and return bit.
  always_ff @(posedge cop_sck or negedge rst_n) begin
    if (!rst_n) begin
      ram_link       <= '{nss: 1'b1, bit_vld: 1'b0, mosi: 1'b0};
      ram_grant_miso <= 1'b0;
      active_q       <= '0;
    end else begin
      // Idle link when the owner has no RAM frame open.
      ram_link.nss     <= !owner_req.active;
      ram_link.bit_vld <= owner_req.bit_vld;
      ram_link.mosi    <= owner_req.mosi;
      for (int i = 0; i < NUM_PORTS; i++) begin
        active_q[i] <= ram_req[i].active;
      end
      // Sampled on the RAM strobe cycle, cleared on an idle bus.
      if (ram_link.nss) begin
        ram_grant_miso <= 1'b0;
      end else if (ram_link.bit_vld) begin
        ram_grant_miso <= ram_miso;
      end
    end
  end

  // Miso return registers.
  always_ff @(posedge cop_sck or negedge rst_n) begin
    if (!rst_n) begin
      port_miso <= '0;
    end else begin
      for (int i = 0; i < COP_PORT; i++) begin
        port_miso[i] <= eng_miso[i];
      end
      // Coprocessor return follows the device route.
      case (dev_route)
        cpld_pkg::DEV_LOGIC:  port_miso[COP_PORT] <= eng_miso[COP_PORT];
        cpld_pkg::DEV_SDCARD,
        cpld_pkg::DEV_USB,
        cpld_pkg::DEV_FPGA:   port_miso[COP_PORT] <= dev_miso;
        default:              port_miso[COP_PORT] <= 1'b0;
      endcase
    end
  end

  // Any engine in a reset frame holds the peer.
  assign peer_nreset = ~(|reset_req);

  // The RAM return bit reaches a single engine frame.
  a_one_ram_user : assert property (@(posedge cop_sck) disable iff (!rst_n)
    ram_link.bit_vld |-> $onehot0(active_q))
    else $error("more than one port in a RAM frame");

endmodule

/* cpld_core_top.sv */
// Top level for 2 to 4 ports; port 0 is the MCU, the last port is the coprocessor with the device select code.
`timescale 1ns/1ps

module cpld_core_top #(
  parameter int NUM_PORTS = 2
) (
  input  logic                 cop_sck,
  input  logic                 rst_n,
  input  cpld_pkg::link_t      port_link [NUM_PORTS],
  input  cpld_pkg::dev_sel_t   cop_select,
  input  logic                 ram_miso,
  input  logic                 dev_miso,
  output logic [NUM_PORTS-1:0] port_miso,
  output cpld_pkg::link_t      ram_link,
  output cpld_pkg::dev_nss_t   dev_nss,
  output logic                 peer_nreset
);

  // Router to engines.
  cpld_pkg::link_t    eng_link [NUM_PORTS];
  cpld_pkg::dev_sel_t dev_route;

  // Engines to arbiter and back.
  cpld_pkg::byte_t      mbox_reg [NUM_PORTS];
  cpld_pkg::ram_req_t   ram_req [NUM_PORTS];
  logic [NUM_PORTS-1:0] eng_miso;
  logic [NUM_PORTS-1:0] reset_req;
  logic                 ram_grant_miso;

  link_router #(
    .NUM_PORTS (NUM_PORTS)
  ) link_router_inst (
    .cop_sck    (cop_sck),
    .rst_n      (rst_n),
    .port_link  (port_link),
    .cop_select (cop_select),
    .eng_link   (eng_link),
    .dev_nss    (dev_nss),
    .dev_route  (dev_route)
  );

  // One engine per port, each reads the next mailbox in the ring.
  for (genvar i = 0; i < NUM_PORTS; i++) begin : g_engine
    frame_engine frame_engine_inst (
      .cop_sck        (cop_sck),
      .rst_n          (rst_n),
      .eng_link       (eng_link[i]),
      .peer_reg       (mbox_reg[(i + 1) % NUM_PORTS]),
      .ram_grant_miso (ram_grant_miso),
      .mbox_reg       (mbox_reg[i]),
      .ram_req        (ram_req[i]),
      .eng_miso       (eng_miso[i]),
      .reset_req      (reset_req[i])
    );
  end

  shared_bus_arbiter #(
    .NUM_PORTS (NUM_PORTS)
  ) shared_bus_arbiter_inst (
    .cop_sck        (cop_sck),
    .rst_n          (rst_n),
    .mbox_reg       (mbox_reg),
    .ram_req        (ram_req),
    .eng_miso       (eng_miso),
    .reset_req      (reset_req),
    .dev_route      (dev_route),
    .ram_miso       (ram_miso),
    .dev_miso       (dev_miso),
    .ram_link       (ram_link),
    .ram_grant_miso (ram_grant_miso),
    .port_miso      (port_miso),
    .peer_nreset    (peer_nreset)
  );

endmodule

/* tb_cpld_core.sv */
// Runs two ports from cpld_stimulus.txt in the run directory; reply bits are sampled in the fourth cycle of each slot.
`timescale 1ns/1ps

module tb_cpld_core;

  localparam int NUM_PORTS  = 2;
  localparam int COP_PORT   = NUM_PORTS - 1;
  localparam int FIELDS     = 6;
  localparam int MAX_FRAMES = 64;
  localparam int BITS       = 16;

  logic                 cop_sck;
  logic                 rst_n;
  cpld_pkg::link_t      port_link [NUM_PORTS];
  cpld_pkg::dev_sel_t   cop_select;
  logic                 ram_miso;
  logic                 dev_miso;
  logic [NUM_PORTS-1:0] port_miso;
  cpld_pkg::link_t      ram_link;
  cpld_pkg::dev_nss_t   dev_nss;
  logic                 peer_nreset;

  // Six words per frame: port, opcode, data, device code, RAM byte, expected reply.
  cpld_pkg::byte_t    stim_mem [MAX_FRAMES*FIELDS];
  int                 num_frames;
  int                 cycle_limit = 200;
  int                 cycle_cnt;
  // Mailbox contents as the frames so far should have left them.
  cpld_pkg::byte_t    mbox_model [NUM_PORTS];
  // RAM byte served during the current frame.
  cpld_pkg::byte_t    cur_ram = 8'h00;
  cpld_pkg::bit_idx_t ram_idx;

  cpld_core_top #(
    .NUM_PORTS (NUM_PORTS)
  ) cpld_core_top_inst (
    .cop_sck     (cop_sck),
    .rst_n       (rst_n),
    .port_link   (port_link),
    .cop_select  (cop_select),
    .ram_miso    (ram_miso),
    .dev_miso    (dev_miso),
    .port_miso   (port_miso),
    .ram_link    (ram_link),
    .dev_nss     (dev_nss),
    .peer_nreset (peer_nreset)
  );

  initial begin
    cop_sck = 1'b0;
    forever #4 cop_sck = ~cop_sck;
  end

  // Watchdog, limit set once the frame count is known.
  initial begin
    cycle_cnt = 0;
    forever begin
      @(posedge cop_sck);
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= cycle_limit) begin
        $display("Timeout: run did not finish within %0d cycles", cycle_limit);
        $display("Test FAILED");
        $fatal(1, "watchdog expired");
      end
    end
  end

  // RAM responder.
  // Bit k of the RAM byte is on ram_miso while the k-th strobe sits on ram_link.
  initial begin
    ram_miso = 1'b0;
    ram_idx  = '0;
    forever begin
      @(posedge cop_sck);
      if (ram_link.nss) begin
        ram_idx  <= '0;
        ram_miso <= cur_ram[0];
      end else if (ram_link.bit_vld) begin
        ram_idx  <= ram_idx + 1'b1;
        ram_miso <= cur_ram[ram_idx + 1'b1];
      end
    end
  end

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Test FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_reply_byte(input string name, input cpld_pkg::byte_t got,
                                  input cpld_pkg::byte_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic verify_ram_link(input string name, input cpld_pkg::link_t got,
                                 input cpld_pkg::link_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic compare_dev_nss(input string name, input cpld_pkg::dev_nss_t got,
                                 input cpld_pkg::dev_nss_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic expect_peer_nreset(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  // First port with a nonzero mailbox, port 0 when all are zero.
  function automatic int ram_owner();
    int owner;
    bit found;
    owner = 0;
    found = 1'b0;
    for (int i = 0; i < NUM_PORTS; i++) begin
      if (!found && mbox_model[i] != 8'h00) begin
        owner = i;
        found = 1'b1;
      end
    end
    return owner;
  endfunction

  // Only the matching chip select goes low.
  function automatic cpld_pkg::dev_nss_t selects_for_code(input cpld_pkg::dev_sel_t code);
    cpld_pkg::dev_nss_t nss;
    nss = cpld_pkg::DEV_NSS_IDLE;
    case (code)
      cpld_pkg::DEV_SDCARD: nss[cpld_pkg::DEV_NSS_SDCARD] = 1'b0;
      cpld_pkg::DEV_USB:    nss[cpld_pkg::DEV_NSS_USB] = 1'b0;
      cpld_pkg::DEV_FPGA:   nss[cpld_pkg::DEV_NSS_FPGA] = 1'b0;
      default:              nss = cpld_pkg::DEV_NSS_IDLE;
    endcase
    return nss;
  endfunction

  // One four-cycle bit slot, entered and left on a rising edge.
  // ram_link is taken in the second cycle, port_miso in the fourth.
  task automatic send_bit_slot(input int port, input logic b, output logic miso_q,
                               output cpld_pkg::link_t ram_q);
    port_link[port].bit_vld <= 1'b1;
    port_link[port].mosi    <= b;
    dev_miso                <= ~b;
    @(posedge cop_sck);
    port_link[port].bit_vld <= 1'b0;
    @(negedge cop_sck);
    ram_q = ram_link;
    @(posedge cop_sck);
    @(posedge cop_sck);
    @(negedge cop_sck);
    miso_q = port_miso[port];
    @(posedge cop_sck);
  endtask

  task automatic play_frame(input int idx);
    int                 port;
    int                 first;
    int unsigned        gap;
    cpld_pkg::byte_t    op;
    cpld_pkg::byte_t    data;
    cpld_pkg::byte_t    exp_reply;
    cpld_pkg::dev_sel_t code;
    logic [BITS-1:0]    frame_bits;
    logic [BITS-1:0]    miso_bits;
    cpld_pkg::link_t    link_q;
    cpld_pkg::link_t    exp_link;
    logic               miso_q;
    logic               logic_route;
    logic               ram_frame;

    port      = int'(stim_mem[idx*FIELDS]);
    op        = stim_mem[idx*FIELDS+1];
    data      = stim_mem[idx*FIELDS+2];
    code      = stim_mem[idx*FIELDS+3][2:0];
    cur_ram   = stim_mem[idx*FIELDS+4];
    exp_reply = stim_mem[idx*FIELDS+5];
    if (port >= NUM_PORTS) begin
      abort_run($sformatf("Frame %0d names port %0d, which does not exist", idx, port));
    end
    // The coprocessor reaches its engine only on the logic code.
    logic_route = (port != COP_PORT) || (code == cpld_pkg::DEV_LOGIC);
    ram_frame   = logic_route && (op == cpld_pkg::OP_ACCESS_RAM);
    // Peer data leads by one slot, its bit 0 follows the last opcode bit.
    first      = (logic_route && op == cpld_pkg::OP_READ_PEER) ? 7 : 8;
    frame_bits = {data, op};
    cop_select <= code;
    gap = $urandom % 4;
    repeat (2 + gap) @(posedge cop_sck);
    port_link[port].nss <= 1'b0;
    @(posedge cop_sck);
    for (int s = 0; s < BITS; s++) begin
      send_bit_slot(port, frame_bits[s], miso_q, link_q);
      miso_bits[s] = miso_q;
      // Data bits reach the RAM one cycle late, only from the owner.
      if (s >= 8) begin
        if (ram_frame && ram_owner() == port) begin
          exp_link = '{nss: 1'b0, bit_vld: 1'b1, mosi: frame_bits[s]};
        end else begin
          exp_link = '{nss: 1'b1, bit_vld: 1'b0, mosi: 1'b0};
        end
        verify_ram_link("ram_link", link_q, exp_link);
      end
    end
    @(negedge cop_sck);
    compare_dev_nss("dev_nss", dev_nss, selects_for_code(code));
    expect_peer_nreset("peer_nreset in frame", peer_nreset,
                       !(logic_route && op == cpld_pkg::OP_PEER_RESET));
    @(posedge cop_sck);
    port_link[port].nss  <= 1'b1;
    port_link[port].mosi <= 1'b0;
    @(negedge cop_sck);
    expect_peer_nreset("peer_nreset after frame", peer_nreset, 1'b1);
    check_reply_byte($sformatf("port_miso[%0d]", port), miso_bits[first +: 8], exp_reply);
    if (logic_route && op == cpld_pkg::OP_WRITE_REG) begin
      mbox_model[port] = data;
    end
    @(posedge cop_sck);
  endtask

  initial begin
    void'($urandom(32'h634e_00f3));
    rst_n      = 1'b0;
    cop_select = cpld_pkg::DEV_LOGIC;
    dev_miso   = 1'b0;
    for (int i = 0; i < NUM_PORTS; i++) begin
      port_link[i]  = '{nss: 1'b1, bit_vld: 1'b0, mosi: 1'b0};
      mbox_model[i] = 8'h00;
    end
    // Words past the end of the file read as the end marker.
    for (int i = 0; i < MAX_FRAMES*FIELDS; i++) begin
      stim_mem[i] = 8'hff;
    end
    $readmemh("cpld_stimulus.txt", stim_mem);
    num_frames = 0;
    while (num_frames < MAX_FRAMES && stim_mem[num_frames*FIELDS] != 8'hff) begin
      num_frames++;
    end
    if (num_frames == 0) begin
      abort_run("No frames found in cpld_stimulus.txt");
    end
    cycle_limit = num_frames * 80 + 200;
    repeat (5) @(posedge cop_sck);
    rst_n <= 1'b1;
    @(negedge cop_sck);
    // Everything idle after reset.
    compare_dev_nss("dev_nss after reset", dev_nss, cpld_pkg::DEV_NSS_IDLE);
    expect_peer_nreset("peer_nreset after reset", peer_nreset, 1'b1);
    verify_ram_link("ram_link after reset", ram_link, '{nss: 1'b1, bit_vld: 1'b0, mosi: 1'b0});
    check_reply_byte("port_miso after reset", cpld_pkg::byte_t'(port_miso), 8'h00);
    @(posedge cop_sck);
    for (int f = 0; f < num_frames; f++) begin
      play_frame(f);
    end
    $display("Test OK");
    $finish;
  end

endmodule

/* cpld_stimulus.txt */
// Columns: port opcode data device_code ram_byte expected_reply, all hex.
// One frame per line; the opcode goes out first, LSB first.
// After reset every mailbox reads zero.
00 02 00 00 00 00
01 02 00 00 00 00
// Writes, then reads through the ring.
00 01 a5 00 00 00
01 02 00 00 00 a5
01 01 3c 00 00 00
00 02 00 00 00 3c
// Port 0 owns the RAM, port 1 sees an idle bus.
00 03 5a 00 c3 c3
01 03 96 00 7e 00
// Clearing port 0 hands the RAM to port 1.
00 01 00 00 00 00
01 03 69 00 e1 e1
00 03 11 00 ff 00
// All mailboxes zero, port 0 owns again.
01 01 00 00 00 00
00 03 81 00 24 24
// Device codes on the coprocessor return inverted mosi.
01 02 55 01 00 aa
01 03 0f 02 00 f0
01 01 c6 03 00 39
// Unused codes return zeros.
01 02 77 05 00 00
01 01 e7 07 00 00
// The routed write above left mailbox 1 alone.
00 02 00 00 00 00
// Peer reset frames.
00 04 12 00 00 00
01 04 34 00 00 00
// Unknown opcodes leave the mailboxes alone.
00 01 4b 00 00 00
01 01 d2 00 00 00
00 9a 5b 00 00 00
01 00 ff 00 00 00
00 02 00 00 00 d2
01 02 00 00 00 4b

/* tb.f */
cpld_pkg.sv
link_router.sv
frame_engine.sv
shared_bus_arbiter.sv
cpld_core_top.sv
tb_cpld_core.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and judges the result from the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_cpld_core -f tb.f -o tb_cpld_core_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_cpld_core_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
  echo "Simulation reported a failure"
  exit 1
fi

echo "Simulation passed"
exit 0
